// File: compile.f
rtl/atsIsaPkg.sv
rtl/atsTimePkg.sv
rtl/atsCommandFsm.sv
rtl/atsRateTicker.sv
rtl/atsClockBank.sv
rtl/atsAlarmBank.sv
rtl/ats21.sv
test/ats21Checker.sv
test/ats21Tb.sv

// File: rtl/ats21.sv
//////////////////////////////////////////////////
// ats21 top level
// multi-clock alarm unit with one command port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ats21 #(
  parameter int numClocks     = 16,
  parameter int numAlarms     = 24,
  parameter int countWidth    = 16,
  parameter int clkIdxWidth   = $clog2(numClocks),
  parameter int alarmIdxWidth = $clog2(numAlarms)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic [15:0]          ctrl,
  output logic                 ready,
  output logic                 ack,
  output logic [numAlarms-1:0] data
);

  import atsTimePkg::*;

  // FSM to banks
  logic                     clkLoad;
  logic                     clkEnWr;
  logic [clkIdxWidth-1:0]   clkIdx;
  rateT                     clkRate;
  logic                     alarmSet;
  logic                     alarmEnWr;
  logic [alarmIdxWidth-1:0] alarmIdx;
  logic [clkIdxWidth-1:0]   alarmClk;
  logic                     flag;
  logic                     alarmCountdown;
  logic [countWidth-1:0]    value;

  // time base and clock state
  logic                            tick2;
  logic                            tick4;
  logic [numClocks*countWidth-1:0] counts;
  logic [numClocks-1:0]            stepped;

  atsCommandFsm #(
    .numClocks(numClocks), .numAlarms(numAlarms), .countWidth(countWidth),
    .clkIdxWidth(clkIdxWidth), .alarmIdxWidth(alarmIdxWidth)
  ) fsmInst (
    .clk(clk), .reset(reset), .req(req), .ctrl(ctrl),
    .ready(ready), .ack(ack),
    .clkLoad(clkLoad), .clkEnWr(clkEnWr), .clkIdx(clkIdx), .clkRate(clkRate),
    .alarmSet(alarmSet), .alarmEnWr(alarmEnWr), .alarmIdx(alarmIdx),
    .alarmClk(alarmClk), .flag(flag), .alarmCountdown(alarmCountdown), .value(value)
  );

  atsRateTicker tickerInst (
    .clk(clk), .reset(reset), .tick2(tick2), .tick4(tick4)
  );

  atsClockBank #(
    .numClocks(numClocks), .countWidth(countWidth), .clkIdxWidth(clkIdxWidth)
  ) clockBankInst (
    .clk(clk), .reset(reset), .tick2(tick2), .tick4(tick4),
    .clkLoad(clkLoad), .clkEnWr(clkEnWr), .clkIdx(clkIdx), .clkRate(clkRate),
    .flag(flag), .value(value), .counts(counts), .stepped(stepped)
  );

  atsAlarmBank #(
    .numClocks(numClocks), .numAlarms(numAlarms), .countWidth(countWidth),
    .clkIdxWidth(clkIdxWidth), .alarmIdxWidth(alarmIdxWidth)
  ) alarmBankInst (
    .clk(clk), .reset(reset), .alarmSet(alarmSet), .alarmEnWr(alarmEnWr),
    .alarmIdx(alarmIdx), .alarmClk(alarmClk), .flag(flag),
    .alarmCountdown(alarmCountdown), .value(value),
    .counts(counts), .stepped(stepped), .data(data)
  );

endmodule

// File: rtl/atsAlarmBank.sv
//////////////////////////////////////////////////
// ats alarm bank
// alarms and timers, match against clocks, hold finished bits
//////////////////////////////////////////////////

`timescale 1ns/1ps

module atsAlarmBank #(
  parameter int numClocks     = 16,
  parameter int numAlarms     = 24,
  parameter int countWidth    = 16,
  parameter int clkIdxWidth   = 4,
  parameter int alarmIdxWidth = 5
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            alarmSet,
  input  logic                            alarmEnWr,
  input  logic [alarmIdxWidth-1:0]        alarmIdx,
  input  logic [clkIdxWidth-1:0]          alarmClk,
  input  logic                            flag,
  input  logic                            alarmCountdown,
  input  logic [countWidth-1:0]           value,
  input  logic [numClocks*countWidth-1:0] counts,
  input  logic [numClocks-1:0]            stepped,
  output logic [numAlarms-1:0]            data
);

  import atsTimePkg::*;

  localparam int holdWidth = $clog2(holdCycles + 1);

  logic [numAlarms-1:0]   enable;
  logic [numAlarms-1:0]   loop;           // re-arm after firing
  logic [clkIdxWidth-1:0] clkSel [numAlarms];
  logic [countWidth-1:0]  target [numAlarms];
  logic [holdWidth-1:0]   hold [numAlarms]; // remaining high cycles
  logic [countWidth-1:0]  clkCount [numClocks];
  logic [numAlarms-1:0]   hit;

  // unpack clock counts for indexed reads
  always_comb begin
    for (int c = 0; c < numClocks; c++) begin
      clkCount[c] = counts[c*countWidth +: countWidth];
    end
  end

  //////////////////////////////////////////////////
  // match detection and outputs
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < numAlarms; i++) begin
      // only a real step onto the target counts, a load does not
      hit[i]  = enable[i] & stepped[clkSel[i]] & (clkCount[clkSel[i]] == target[i]);
      data[i] = (hold[i] != '0);
    end
  end

  //////////////////////////////////////////////////
  // alarm registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enable <= '0;
      loop   <= '0;
      for (int i = 0; i < numAlarms; i++) begin
        clkSel[i] <= '0;
        target[i] <= '0;
        hold[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < numAlarms; i++) begin
        // finished bit timing
        if (hit[i]) begin
          hold[i] <= holdWidth'(holdCycles);
        end else if (hold[i] != '0) begin
          hold[i] <= hold[i] - 1'b1;
        end

        if (alarmSet && alarmIdx == i) begin
          enable[i] <= 1'b1;                      // set arms the alarm
          clkSel[i] <= alarmClk;
          loop[i]   <= flag & ~alarmCountdown;    // timers never repeat
          if (alarmCountdown) begin
            target[i] <= value + clkCount[alarmClk]; // duration from now
          end else begin
            target[i] <= value;
          end
        end else if (alarmEnWr && alarmIdx == i) begin
          enable[i] <= flag;
        end else if (hit[i] && !loop[i]) begin
          enable[i] <= 1'b0; // one-shot done
        end
      end
    end
  end

endmodule

// File: rtl/atsClockBank.sv
//////////////////////////////////////////////////
// ats clock bank
// free-counting clocks with load, enable and rate stepping
//////////////////////////////////////////////////

`timescale 1ns/1ps

module atsClockBank #(
  parameter int numClocks   = 16,
  parameter int countWidth  = 16,
  parameter int clkIdxWidth = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            tick2,
  input  logic                            tick4,
  input  logic                            clkLoad,
  input  logic                            clkEnWr,
  input  logic [clkIdxWidth-1:0]          clkIdx,
  input  atsTimePkg::rateT                clkRate,
  input  logic                            flag,
  input  logic [countWidth-1:0]           value,
  output logic [numClocks*countWidth-1:0] counts,
  output logic [numClocks-1:0]            stepped
);

  import atsTimePkg::*;

  logic [countWidth-1:0] count [numClocks];
  rateT                  rate [numClocks];
  logic [numClocks-1:0]  enable;
  logic [numClocks-1:0]  stepEn; // clock advances at the coming edge

  //////////////////////////////////////////////////
  // rate gating and count packing
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < numClocks; i++) begin
      case (rate[i])
        rate1x:  stepEn[i] = enable[i];         // no tick needed
        rate2x:  stepEn[i] = enable[i] & tick2;
        rate4x:  stepEn[i] = enable[i] & tick4;
        default: stepEn[i] = 1'b0;
      endcase
      counts[i*countWidth +: countWidth] = count[i];
    end
  end

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enable  <= '0;
      stepped <= '0;
      for (int i = 0; i < numClocks; i++) begin
        count[i] <= '0;
        rate[i]  <= rate1x;
      end
    end else begin
      for (int i = 0; i < numClocks; i++) begin
        if (clkLoad && clkIdx == i) begin
          count[i]   <= value;   // load wins over stepping
          rate[i]    <= clkRate;
          enable[i]  <= 1'b1;
          stepped[i] <= 1'b0;    // a load is not a step
        end else begin
          if (clkEnWr && clkIdx == i) begin
            enable[i] <= flag;   // rate and count kept
          end
          if (stepEn[i]) begin
            count[i] <= count[i] + 1'b1; // wraps modulo 2^countWidth
          end
          stepped[i] <= stepEn[i];
        end
      end
    end
  end

endmodule

// File: rtl/atsCommandFsm.sv
//////////////////////////////////////////////////
// ats command FSM
// joins instruction halves, checks them, drives bank writes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module atsCommandFsm #(
  parameter int numClocks     = 16,
  parameter int numAlarms     = 24,
  parameter int countWidth    = 16,
  parameter int clkIdxWidth   = 4,
  parameter int alarmIdxWidth = 5
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  logic [15:0]              ctrl,
  output logic                     ready,
  output logic                     ack,
  output logic                     clkLoad,
  output logic                     clkEnWr,
  output logic [clkIdxWidth-1:0]   clkIdx,
  output atsTimePkg::rateT         clkRate,
  output logic                     alarmSet,
  output logic                     alarmEnWr,
  output logic [alarmIdxWidth-1:0] alarmIdx,
  output logic [clkIdxWidth-1:0]   alarmClk,
  output logic                     flag,
  output logic                     alarmCountdown,
  output logic [countWidth-1:0]    value
);

  import atsIsaPkg::*;
  import atsTimePkg::*;

  localparam int halfWidth = 16; // ctrl carries one half per req cycle

  typedef enum logic {waitTop, waitBottom} stateT;

  stateT       state;
  logic [15:0] topHalf;   // upper instruction half, held one cycle
  logic [31:0] instr;
  opcodeT      topOpcode; // opcode seen on ctrl while waiting for a top half
  opcodeT      opcode;
  rateT        rateField;
  logic        clkOk, alarmOk, srcOk;
  logic        ackNext, loadNext, enWrNext, setNext, alarmEnNext;

  assign instr     = {topHalf, ctrl};
  assign topOpcode = opcodeT'(ctrl[opcodeMsb-halfWidth -: 3]);

  //////////////////////////////////////////////////
  // decode of the full instruction
  //////////////////////////////////////////////////
  always_comb begin
    opcode    = opcodeT'(instr[opcodeMsb -: 3]);
    rateField = rateT'(instr[rateMsb:rateLsb]);
    clkOk     = instr[clockIdxMsb:clockIdxLsb] < numClocks;     // clock number exists
    alarmOk   = instr[alarmIdxMsb:alarmIdxLsb] < numAlarms;     // 24..31 rejected
    srcOk     = instr[alarmClockMsb:alarmClockLsb] < numClocks; // watched clock exists
    ackNext     = 1'b0;
    loadNext    = 1'b0;
    enWrNext    = 1'b0;
    setNext     = 1'b0;
    alarmEnNext = 1'b0;
    case (opcode)
      opSetClock: begin
        if (clkOk && rateField != rateBad) begin
          ackNext  = 1'b1;
          loadNext = 1'b1;
        end
      end
      opClockEnable: begin
        ackNext  = clkOk;
        enWrNext = clkOk;
      end
      opSetAlarm, opSetTimer: begin // same write, countdown bit differs
        ackNext = alarmOk && srcOk;
        setNext = alarmOk && srcOk;
      end
      opAlarmEnable: begin
        ackNext     = alarmOk;
        alarmEnNext = alarmOk;
      end
      default: ackNext = 1'b0; // set mode, 3'b100, nop
    endcase
  end

  //////////////////////////////////////////////////
  // state, response and write strobes
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= waitTop;
      ready     <= 1'b0;
      ack       <= 1'b0;
      clkLoad   <= 1'b0;
      clkEnWr   <= 1'b0;
      alarmSet  <= 1'b0;
      alarmEnWr <= 1'b0;
    end else begin
      ready     <= 1'b0; // all strobes last one cycle
      ack       <= 1'b0;
      clkLoad   <= 1'b0;
      clkEnWr   <= 1'b0;
      alarmSet  <= 1'b0;
      alarmEnWr <= 1'b0;
      case (state)
        waitTop: begin
          if (req && topOpcode != opNop) begin
            state <= waitBottom;
          end
        end
        waitBottom: begin
          state <= waitTop; // low req abandons silently
          if (req) begin
            ready     <= 1'b1;
            ack       <= ackNext;
            clkLoad   <= loadNext;
            clkEnWr   <= enWrNext;
            alarmSet  <= setNext;
            alarmEnWr <= alarmEnNext;
          end
        end
      endcase
    end
  end

  // top half capture and field registers
  always_ff @(posedge clk) begin
    if (state == waitTop && req) begin
      topHalf <= ctrl;
    end
    if (state == waitBottom && req) begin
      clkIdx         <= clkIdxWidth'(instr[clockIdxMsb:clockIdxLsb]);
      clkRate        <= rateField;
      alarmIdx       <= alarmIdxWidth'(instr[alarmIdxMsb:alarmIdxLsb]);
      alarmClk       <= clkIdxWidth'(instr[alarmClockMsb:alarmClockLsb]);
      flag           <= instr[flagBit];
      alarmCountdown <= (opcode == opSetTimer);
      value          <= countWidth'(instr[valueMsb:0]);
    end
  end

endmodule

// File: rtl/atsIsaPkg.sv
//////////////////////////////////////////////////
// ats instruction set
// opcodes and bit positions of the 32-bit instruction
//////////////////////////////////////////////////

package atsIsaPkg;

  //////////////////////////////////////////////////
  // opcodes, instruction bits [31:29]
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    opNop         = 3'b000, // never accepted as a top half
    opSetClock    = 3'b001, // load count and rate, enables clock
    opClockEnable = 3'b010, // enable or disable one clock
    opSetMode     = 3'b011, // not supported, answers nack
    opSetAlarm    = 3'b101, // absolute alarm, one-shot or repeating
    opSetTimer    = 3'b110, // countdown against current clock count
    opAlarmEnable = 3'b111  // enable or disable one alarm
  } opcodeT;                // 3'b100 left unnamed, also nack

  //////////////////////////////////////////////////
  // field positions in the full instruction
  //////////////////////////////////////////////////
  localparam int opcodeMsb     = 31; // 3-bit opcode ends here
  localparam int clockIdxMsb   = 28; // clock number, clock opcodes
  localparam int clockIdxLsb   = 25;
  localparam int alarmIdxMsb   = 28; // alarm number, alarm opcodes
  localparam int alarmIdxLsb   = 24;
  localparam int flagBit       = 23; // enable, or loop for set alarm
  localparam int rateMsb       = 23; // step rate, set clock only
  localparam int rateLsb       = 22;
  localparam int alarmClockMsb = 19; // clock an alarm watches
  localparam int alarmClockLsb = 16;
  localparam int valueMsb      = 15; // count, target or duration

endpackage

// File: rtl/atsRateTicker.sv
//////////////////////////////////////////////////
// ats rate ticker
// prescaler for the half and quarter rate step ticks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module atsRateTicker (
  input  logic clk,
  input  logic reset,
  output logic tick2,
  output logic tick4
);

  logic [1:0] phase; // free-running, wraps every 4 cycles

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  // one tick in two cycles
  assign tick2 = phase[0];

  // one tick in four cycles, coincides with a tick2
  assign tick4 = (phase == 2'd3);

endmodule

// File: rtl/atsTimePkg.sv
//////////////////////////////////////////////////
// ats time base
// clock step rates and alarm output hold length
//////////////////////////////////////////////////

package atsTimePkg;

  // step rate of one clock relative to clk
  typedef enum logic [1:0] {
    rate1x  = 2'b00, // every cycle
    rate2x  = 2'b01, // every second cycle
    rate4x  = 2'b10, // every fourth cycle
    rateBad = 2'b11  // rejected by the command decoder
  } rateT;

  // cycles a finished bit stays high after a match
  localparam int holdCycles = 2;

endpackage

// File: test/ats21Checker.sv
//////////////////////////////////////////////////
// ats21 checker
// compares ready/ack and alarm pulses with expectations
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ats21Checker #(
  parameter int numAlarms = 24
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ready,
  input  logic                 ack,
  input  logic [numAlarms-1:0] data,
  input  logic                 expStrobe, // bottom half on the bus this cycle
  input  logic                 expAck,
  input  logic [7:0]           expWatch,  // 8'hff when no alarm is watched
  input  int                   expLo,     // window, cycles after ready
  input  int                   expHi,
  input  logic                 finish,
  output int                   errorCount,
  output logic                 reported
);

  import atsTimePkg::*;

  int                   cycle;
  int                   checkCount;
  logic                 readyDue;   // one response outstanding
  int                   readyCycle;
  logic                 ackWant;
  logic [numAlarms-1:0] windowOpen;
  int                   windowBase [numAlarms]; // ready cycle of the arming line
  int                   windowLo [numAlarms];
  int                   windowHi [numAlarms];
  int                   highRun [numAlarms];    // cycles the bit has been high
  logic [numAlarms-1:0] prevData;

  initial begin
    errorCount = 0;
    checkCount = 0;
    reported   = 1'b0;
    cycle      = 0;
    readyDue   = 1'b0;
    windowOpen = '0;
    prevData   = '0;
    foreach (highRun[i]) highRun[i] = 0;
  end

  //////////////////////////////////////////////////
  // response and pulse checks
  //////////////////////////////////////////////////
  task automatic compareResponse();
    if (readyDue && cycle == readyCycle) begin
      checkCount++;
      readyDue = 1'b0;
      if (ready !== 1'b1) begin
        $display("ready missing in cycle %0d after a completed instruction", cycle);
        errorCount++;
      end else if (ack !== ackWant) begin
        $display("mismatch ack: expected %0h got %0h in cycle %0d", ackWant, ack, cycle);
        errorCount++;
      end
    end else if (ready !== 1'b0) begin
      $display("ready seen in cycle %0d with no instruction completed", cycle);
      errorCount++;
    end
  endtask

  task automatic watchPulses();
    for (int i = 0; i < numAlarms; i++) begin
      if (data[i] === 1'b1 && !prevData[i]) begin // rising bit
        highRun[i] = 1;
        if (!windowOpen[i]) begin
          $display("alarm %0d pulsed in cycle %0d when no pulse was expected", i, cycle);
          errorCount++;
        end else if (cycle < windowLo[i] || cycle > windowHi[i]) begin
          $display("alarm %0d pulsed %0d cycles after ready, outside %0d to %0d", i,
                   cycle - windowBase[i], windowLo[i] - windowBase[i],
                   windowHi[i] - windowBase[i]);
          errorCount++;
        end else begin
          checkCount++;
        end
        windowOpen[i] = 1'b0;
      end else if (data[i] === 1'b1) begin
        highRun[i]++;
      end else if (prevData[i] && highRun[i] != holdCycles) begin
        $display("mismatch data[%0d] high cycles: expected %0h got %0h", i, holdCycles,
                 highRun[i]);
        errorCount++;
      end
      if (windowOpen[i] && cycle > windowHi[i]) begin
        $display("alarm %0d never pulsed inside its window", i);
        errorCount++;
        windowOpen[i] = 1'b0;
      end
      prevData[i] = (data[i] === 1'b1);
    end
  endtask

  task automatic reportTotals();
    if (readyDue) begin
      $display("run ended with a ready still outstanding");
      errorCount++;
    end
    for (int i = 0; i < numAlarms; i++) begin
      if (windowOpen[i]) begin
        $display("run ended before alarm %0d pulsed", i);
        errorCount++;
      end
    end
    $display("checker: %0d checks, %0d errors", checkCount, errorCount);
    reported = 1'b1;
  endtask

  // sample at the falling edge, outputs settled
  always @(negedge clk) begin
    if (!reset && !reported) begin
      cycle++;
      compareResponse();
      if (expStrobe) begin
        readyDue   = 1'b1;
        readyCycle = cycle + 1; // ready follows the bottom half
        ackWant    = expAck;
        if (expWatch != 8'hff && expWatch >= numAlarms) begin
          $display("stim asks to watch alarm %0d, which does not exist", expWatch);
          errorCount++;
        end else if (expWatch != 8'hff) begin
          windowOpen[expWatch] = 1'b1;
          windowBase[expWatch] = cycle + 1;
          windowLo[expWatch]   = cycle + 1 + expLo;
          windowHi[expWatch]   = cycle + 1 + expHi;
        end
      end
      watchPulses();
      if (finish) begin
        reportTotals();
      end
    end
  end

endmodule

// File: test/ats21Stim.txt
# top bottom ack watch earliest latest gap; halves/ack/watch hex, rest decimal cycles
# ack 2 = bottom half withheld, watch ff = none, window counted from the ready cycle
# responses and nack cases
6000 0000 0 ff 0 0 0
8000 0000 0 ff 0 0 0
20C0 0000 0 ff 0 0 0
B800 0000 0 ff 0 0 0
FF00 0000 0 ff 0 0 0
2600 0100 2 ff 0 0 2
# one-shot alarm 5 on clock 3 at 1x, then reload with no second pulse
2600 0100 1 ff 0 0 0
A503 0114 1 05 20 20 30
2600 0100 1 ff 0 0 40
# repeating alarm 7 on clock 4 at 4x, fires again after reload
2880 0200 1 ff 0 0 0
A784 0205 1 07 17 20 30
2880 0200 1 07 19 22 30
# countdown alarm 9 on clock 6 at 2x
2C40 1000 1 ff 0 0 10
C906 0008 1 09 16 17 30
# alarm 10 disabled before its match
CA03 0020 1 ff 0 0 0
EA00 0000 1 ff 0 0 50
# clock 8 stopped under timer 11, then restarted
3000 0000 1 ff 0 0 0
CB08 0030 1 ff 0 0 0
5000 0000 1 ff 0 0 80
5080 0000 1 0b 47 47 60
EA80 0000 1 ff 0 0 5

// File: test/ats21Tb.sv
//////////////////////////////////////////////////
// ats21 testbench
// drives instructions from the stim file, reset and timeout
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ats21Tb;

  localparam int numClocks  = 16;
  localparam int numAlarms  = 24;
  localparam int countWidth = 16;
  localparam int abandonAck = 2; // ack column code, bottom half withheld

  logic                 clk;
  logic                 reset;
  logic                 req;
  logic [15:0]          ctrl;
  logic                 ready;
  logic                 ack;
  logic [numAlarms-1:0] data;

  // expectations for the checker
  logic       expStrobe;
  logic       expAck;
  logic [7:0] expWatch;
  int         expLo;
  int         expHi;
  logic       finish;
  int         errorCount;
  logic       reported;

  // stim table, one entry per line
  int   topQ[$];
  int   bottomQ[$];
  int   ackQ[$];
  int   watchQ[$];
  int   loQ[$];
  int   hiQ[$];
  int   gapQ[$];
  int   cycleCount;
  int   cycleLimit; // 0 until the stim file is read
  logic stimOk;

  ats21 #(
    .numClocks(numClocks), .numAlarms(numAlarms), .countWidth(countWidth)
  ) ats21_inst (
    .clk(clk), .reset(reset), .req(req), .ctrl(ctrl),
    .ready(ready), .ack(ack), .data(data)
  );

  ats21Checker #(.numAlarms(numAlarms)) checkerInst (
    .clk(clk), .reset(reset), .ready(ready), .ack(ack), .data(data),
    .expStrobe(expStrobe), .expAck(expAck), .expWatch(expWatch),
    .expLo(expLo), .expHi(expHi), .finish(finish),
    .errorCount(errorCount), .reported(reported)
  );

  always #5 clk = ~clk; // 10 ns period

  // run limit from gaps and windows
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout: run not done after %0d cycles, %0d errors so far", cycleLimit,
               errorCount);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stim file and instruction driving
  //////////////////////////////////////////////////
  task automatic loadStim(output logic ok);
    int               fd;
    int               code;
    int               lineNo;
    int               total;
    int               top, bottom, ackCode, watch;
    int               lo, hi, gap;
    logic [8*128-1:0] line;
    ok     = 1'b1;
    lineNo = 0;
    total  = 0;
    fd     = $fopen("test/ats21Stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/ats21Stim.txt");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) > 0) begin
        lineNo++;
        code = $sscanf(line, "%h %h %h %h %d %d %d", top, bottom, ackCode, watch, lo, hi, gap);
        if (code == 7) begin
          topQ.push_back(top);
          bottomQ.push_back(bottom);
          ackQ.push_back(ackCode);
          watchQ.push_back(watch);
          loQ.push_back(lo);
          hiQ.push_back(hi);
          gapQ.push_back(gap);
          total += gap + hi;
        end else if (code > 0) begin // comment lines scan as 0
          $display("stim line %0d is malformed", lineNo);
          ok = 1'b0;
        end
      end
    end
    $fclose(fd);
    if (topQ.size() == 0) begin
      $display("no tests found in test/ats21Stim.txt");
      ok = 1'b0;
    end
    cycleLimit = 2 * total + 100;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic sendInstr(input int idx);
    req  = 1'b1;
    ctrl = 16'(topQ[idx]);
    nextCycle();
    if (ackQ[idx] == abandonAck) begin
      req  = 1'b0; // low req drops the instruction
      ctrl = '0;
    end else begin
      ctrl      = 16'(bottomQ[idx]);
      expStrobe = 1'b1;
      expAck    = (ackQ[idx] == 1);
      expWatch  = 8'(watchQ[idx]);
      expLo     = loQ[idx];
      expHi     = hiQ[idx];
    end
    nextCycle();
    req       = 1'b0;
    ctrl      = '0;
    expStrobe = 1'b0;
    repeat (gapQ[idx]) nextCycle();
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req        = 1'b0;
    ctrl       = '0;
    expStrobe  = 1'b0;
    expAck     = 1'b0;
    expWatch   = 8'hff;
    expLo      = 0;
    expHi      = 0;
    finish     = 1'b0;
    cycleCount = 0;
    cycleLimit = 0;
    loadStim(stimOk);
    if (!stimOk) begin
      $display("*** FAILED ***");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (2) nextCycle();
      foreach (topQ[i]) sendInstr(i);
      finish = 1'b1;
      wait (reported === 1'b1);
      if (errorCount == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule
